//--- design/alu_pkg.sv
package alu_pkg;

    // Q6.10 word format
    localparam int DATA_W = 16;
    localparam int FRAC_W = 10;

    typedef logic signed [DATA_W-1:0]   fx_t;
    typedef logic signed [2*DATA_W-1:0] prod_t;  // full product, 20 fraction bits
    typedef logic [4:0]                 cnt_t;   // 0..16

    // codes 4, 8 and 9 are left unassigned
    typedef enum logic [3:0] {
        OP_FXADD = 4'd0,
        OP_FXSUB = 4'd1,
        OP_FXMUL = 4'd2,
        OP_FXMAC = 4'd3,
        OP_CLZ   = 4'd5,
        OP_LRCW  = 4'd6,
        OP_LFSR  = 4'd7
    } op_e;

    typedef struct packed {
        op_e op;
        fx_t a;
        fx_t b;
    } alu_req_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_CALC = 2'd1,
        ST_ACK  = 2'd2
    } ctrl_state_e;

    // saturation limits
    localparam fx_t FX_MAX = 16'sh7FFF;
    localparam fx_t FX_MIN = 16'sh8000;

endpackage

//--- design/fx_arith.sv
`timescale 1ns/10ps

module fx_arith import alu_pkg::*; (
    input  alu_req_t i_cmd,
    input  fx_t      i_acc,
    output fx_t      o_res
);

    // product range that still fits Q6.10 before rounding
    localparam prod_t PROD_MAX = (prod_t'(FX_MAX) <<< FRAC_W) + prod_t'(2**FRAC_W - 1);
    localparam prod_t PROD_MIN = prod_t'(FX_MIN) <<< FRAC_W;

    logic signed [DATA_W:0] sum;
    logic signed [DATA_W:0] diff;
    prod_t                  prod;
    prod_t                  mac;

    // clamp a 17-bit value into the 16-bit word
    function automatic fx_t sat17(input logic signed [DATA_W:0] v);
        logic signed [DATA_W:0] hi;
        logic signed [DATA_W:0] lo;
        hi = FX_MAX;
        lo = FX_MIN;
        if (v > hi) begin
            return FX_MAX;
        end
        if (v < lo) begin
            return FX_MIN;
        end
        return fx_t'(v[DATA_W-1:0]);
    endfunction

    // drop 10 fraction bits, round half up, saturate on both sides
    function automatic fx_t round_sat(input prod_t p);
        logic signed [DATA_W:0] r;
        if (p > PROD_MAX) begin
            return FX_MAX;
        end
        if (p < PROD_MIN) begin
            return FX_MIN;
        end
        r = {p[FRAC_W+DATA_W-1], p[FRAC_W +: DATA_W]} + (DATA_W+1)'(p[FRAC_W-1]);
        return sat17(r);  // 0x7FFF + half must not wrap
    endfunction

    assign sum  = {i_cmd.a[DATA_W-1], i_cmd.a} + {i_cmd.b[DATA_W-1], i_cmd.b};
    assign diff = {i_cmd.a[DATA_W-1], i_cmd.a} - {i_cmd.b[DATA_W-1], i_cmd.b};

    assign prod = i_cmd.a * i_cmd.b;
    // previous result aligned to 20 fraction bits
    assign mac  = prod + (prod_t'(i_acc) <<< FRAC_W);

    always_comb begin
        case (i_cmd.op)
            OP_FXADD: o_res = sat17(sum);
            OP_FXSUB: o_res = sat17(diff);
            OP_FXMUL: o_res = round_sat(prod);
            OP_FXMAC: o_res = round_sat(mac);
            default:  o_res = '0;  // bit ops and unused codes
        endcase
    end

endmodule

//--- design/bit_ops.sv
`timescale 1ns/10ps

module bit_ops import alu_pkg::*; #(
    parameter int LFSR_MAX_STEPS = 8
) (
    input  alu_req_t i_cmd,
    output fx_t      o_res
);

    // zeros above the first set bit, 16 for an all-zero word
    function automatic cnt_t clz16(input fx_t v);
        cnt_t n;
        logic hit;
        n   = '0;
        hit = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    function automatic cnt_t popcount(input fx_t v);
        cnt_t n;
        n = '0;
        for (int i = 0; i < DATA_W; i++) begin
            n = n + cnt_t'(v[i]);
        end
        return n;
    endfunction

    // rotate b left by popcount(a), wrapped bits come back inverted
    function automatic fx_t lrcw(input fx_t a, input fx_t b);
        logic [DATA_W-1:0] ub;
        cnt_t              n;
        n  = popcount(a);
        ub = b;
        return fx_t'((ub << n) | (~ub >> (DATA_W - n)));
    endfunction

    function automatic fx_t lfsr_adv(input fx_t seed, input fx_t steps);
        logic [DATA_W-1:0] r;
        r = seed;
        if ($unsigned(steps) > LFSR_MAX_STEPS) begin
            return '0;
        end
        for (int i = 0; i < LFSR_MAX_STEPS; i++) begin
            if (i < $unsigned(steps)) begin
                r = {r[DATA_W-2:0], r[15] ^ r[13] ^ r[12] ^ r[10]};  // taps 16,14,13,11
            end
        end
        return fx_t'(r);
    endfunction

    always_comb begin
        case (i_cmd.op)
            OP_CLZ:  o_res = fx_t'(clz16(i_cmd.a));
            OP_LRCW: o_res = lrcw(i_cmd.a, i_cmd.b);
            OP_LFSR: o_res = lfsr_adv(i_cmd.a, i_cmd.b);  // b is the step count
            default: o_res = '0;
        endcase
    end

endmodule

//--- design/alu_ctrl.sv
`timescale 1ns/10ps

module alu_ctrl import alu_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_req,
    input  alu_req_t i_cmd,
    input  fx_t      i_arith_res,
    input  fx_t      i_bits_res,
    output alu_req_t o_cmd_q,
    output fx_t      o_acc_q,
    output logic     o_ack,
    output fx_t      o_result
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    alu_req_t    cmd_q;
    fx_t         result_q;  // also the accumulator for mac
    fx_t         sel_res;
    logic        accept;

    assign accept = (state_q == ST_IDLE) && i_req;

    // four-phase handshake
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_req) begin
                    state_d = ST_CALC;
                end
            end
            ST_CALC: begin
                state_d = ST_ACK;  // datapaths settle in one cycle
            end
            ST_ACK: begin
                if (!i_req) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd_q <= i_cmd;
        end
    end

    // result source by opcode class
    always_comb begin
        case (cmd_q.op)
            OP_FXADD, OP_FXSUB, OP_FXMUL, OP_FXMAC: begin
                sel_res = i_arith_res;
            end
            OP_CLZ, OP_LRCW, OP_LFSR: begin
                sel_res = i_bits_res;
            end
            default: begin
                sel_res = '0;  // undefined opcode
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            result_q <= '0;
        end else if (state_q == ST_CALC) begin
            result_q <= sel_res;
        end
    end

    assign o_cmd_q  = cmd_q;
    assign o_acc_q  = result_q;
    assign o_result = result_q;  // held through ST_ACK
    assign o_ack    = (state_q == ST_ACK);

endmodule

//--- design/alu_top.sv
`timescale 1ns/10ps

module alu_top import alu_pkg::*; #(
    parameter int LFSR_MAX_STEPS = 8
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_req,
    input  alu_req_t i_cmd,
    output logic     o_ack,
    output fx_t      o_result
);

    alu_req_t cmd_q;
    fx_t      acc_q;
    fx_t      arith_res;
    fx_t      bits_res;

    alu_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_cmd       (i_cmd),
        .i_arith_res (arith_res),
        .i_bits_res  (bits_res),
        .o_cmd_q     (cmd_q),
        .o_acc_q     (acc_q),
        .o_ack       (o_ack),
        .o_result    (o_result)
    );

    fx_arith u_fx_arith (
        .i_cmd (cmd_q),
        .i_acc (acc_q),
        .o_res (arith_res)
    );

    bit_ops #(
        .LFSR_MAX_STEPS (LFSR_MAX_STEPS)
    ) u_bit_ops (
        .i_cmd (cmd_q),
        .o_res (bits_res)
    );

endmodule

//--- dv/alu_sva.sv
`timescale 1ns/10ps

module alu_sva import alu_pkg::*; (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_req,
    input logic        i_ack,
    input fx_t         i_result,
    input ctrl_state_e i_state
);

    // ack only answers a request
    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_ack) |-> $past(i_req))
        else $error("o_ack rose without i_req");

    result_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ack |=> $stable(i_result))
        else $error("o_result changed while o_ack was high");

    ack_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ST_ACK && !i_req) |=> !i_ack)
        else $error("o_ack stayed high after i_req dropped");

    // accept, calc, then ack
    ack_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ST_IDLE && i_req) |=> !i_ack ##1 i_ack)
        else $error("o_ack latency is not two edges");

endmodule

bind alu_ctrl alu_sva u_sva (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_req    (i_req),
    .i_ack    (o_ack),
    .i_result (o_result),
    .i_state  (state_q)
);

//--- dv/alu_ref.svh
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// clamp a wide integer into the Q6.10 range
function automatic fx_t clamp_fx(input longint v);
    if (v > 32767) begin
        return FX_MAX;
    end
    if (v < -32768) begin
        return FX_MIN;
    end
    return fx_t'(v);
endfunction

// add, sub, mul and mac; acc is the last result the model holds
function automatic fx_t ref_fx(input alu_req_t cmd, input fx_t acc);
    fx_t    sa;
    fx_t    sb;
    longint a;
    longint b;
    longint p;
    sa = cmd.a;
    sb = cmd.b;
    a  = sa;
    b  = sb;
    case (cmd.op)
        OP_FXADD: return clamp_fx(a + b);
        OP_FXSUB: return clamp_fx(a - b);
        OP_FXMUL, OP_FXMAC: begin
            p = a * b;  // 20 fraction bits
            if (cmd.op == OP_FXMAC) begin
                p = p + longint'(acc) * (longint'(1) << FRAC_W);
            end
            // round half up, then saturate
            return clamp_fx((p + (longint'(1) << (FRAC_W - 1))) >>> FRAC_W);
        end
        default: return '0;
    endcase
endfunction

function automatic cnt_t ref_clz(input fx_t v);
    int top;
    top = -1;
    for (int i = 0; i < DATA_W; i++) begin
        if (v[i]) begin
            top = i;  // highest set bit wins
        end
    end
    return cnt_t'(DATA_W - 1 - top);
endfunction

function automatic fx_t ref_lrcw(input fx_t a, input fx_t b);
    int                n;
    logic [DATA_W-1:0] r;
    n = $countones(a);
    for (int i = 0; i < DATA_W; i++) begin
        if (i >= n) begin
            r[i] = b[i - n];
        end else begin
            r[i] = ~b[DATA_W - n + i];  // wrapped bits come back inverted
        end
    end
    return fx_t'(r);
endfunction

function automatic fx_t ref_lfsr(input fx_t seed, input fx_t steps, input int max_steps);
    logic [DATA_W-1:0] r;
    logic              fb;
    int                cnt;
    cnt = int'($unsigned(steps));
    if (cnt > max_steps) begin
        return '0;
    end
    r = seed;
    repeat (cnt) begin
        fb = ^(r & 16'hB400);  // taps at bits 15, 13, 12 and 10
        r  = (r << 1) | DATA_W'(fb);
    end
    return fx_t'(r);
endfunction

function automatic fx_t ref_bits(input alu_req_t cmd, input int max_steps);
    case (cmd.op)
        OP_CLZ:  return fx_t'(ref_clz(cmd.a));
        OP_LRCW: return ref_lrcw(cmd.a, cmd.b);
        OP_LFSR: return ref_lfsr(cmd.a, cmd.b, max_steps);
        default: return '0;
    endcase
endfunction

`endif

//--- dv/alu_tb.sv
`timescale 1ns/10ps

module alu_tb import alu_pkg::*; ();

    localparam int          LFSR_STEPS  = 8;
    localparam int          ACK_TIMEOUT = 20;
    localparam int unsigned SEED        = 32'h377d5145;
    localparam logic [3:0]  UNDEF_CODES [3] = '{4'd4, 4'd8, 4'd9};

    typedef struct packed {
        logic is_cnt;  // leading-zero count result
        fx_t  got;
        fx_t  exp;
    } check_item_t;

    logic     clk;
    logic     rst_n;
    logic     req;
    alu_req_t cmd;
    logic     ack;
    fx_t      result;

    fx_t         model_acc;  // last result as the model sees it
    check_item_t check_q[$];
    int          checks;
    int          passed;
    int          errors;
    int          test_checks0;
    int          test_errors0;

    `include "alu_ref.svh"

    alu_top #(
        .LFSR_MAX_STEPS (LFSR_STEPS)
    ) dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_req    (req),
        .i_cmd    (cmd),
        .o_ack    (ack),
        .o_result (result)
    );

    always #2 clk = ~clk;

    task automatic check_fx(input string name, input fx_t got, input fx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%04h, expected 0x%04h", name, got, exp);
        end else begin
            passed++;
        end
    endtask

    task automatic check_cnt(input string name, input fx_t got, input cnt_t exp);
        checks++;
        if (got !== fx_t'(exp)) begin
            errors++;
            $display("FAIL %s: got 0x%04h, expected 0x%02h", name, got, exp);
        end else begin
            passed++;
        end
    endtask

    // compares what the request driver collected
    always @(posedge clk) begin : compare_proc
        check_item_t item;
        while (check_q.size() > 0) begin
            item = check_q.pop_front();
            if (item.is_cnt) begin
                check_cnt("o_result", item.got, cnt_t'(item.exp));
            end else begin
                check_fx("o_result", item.got, item.exp);
            end
        end
    end

    function automatic fx_t expect_result(input alu_req_t c, input fx_t acc);
        case (c.op)
            OP_CLZ, OP_LRCW, OP_LFSR: return ref_bits(c, LFSR_STEPS);
            default:                  return ref_fx(c, acc);
        endcase
    endfunction

    function automatic alu_req_t make_cmd(input op_e op, input fx_t a, input fx_t b);
        alu_req_t c;
        c.op = op;
        c.a  = a;
        c.b  = b;
        return c;
    endfunction

    function automatic fx_t rand_fx();
        return fx_t'($urandom);
    endfunction

    function automatic fx_t rand_small();
        return fx_t'(int'($urandom % 8192) - 4096);  // about +-4.0
    endfunction

    function automatic op_e pick_op(input int unsigned r);
        case (r % 7)
            0:       return OP_FXADD;
            1:       return OP_FXSUB;
            2:       return OP_FXMUL;
            3:       return OP_FXMAC;
            4:       return OP_CLZ;
            5:       return OP_LRCW;
            default: return OP_LFSR;
        endcase
    endfunction

    task automatic push_check(input logic is_cnt, input fx_t got, input fx_t exp);
        check_item_t item;
        item.is_cnt = is_cnt;
        item.got    = got;
        item.exp    = exp;
        check_q.push_back(item);
    endtask

    // one four-phase exchange, i_req held for hold extra cycles
    task automatic run_request(input alu_req_t c, input int hold);
        fx_t  exp;
        logic is_cnt;
        int   waited;
        exp    = expect_result(c, model_acc);
        is_cnt = (c.op == OP_CLZ);
        @(posedge clk);
        #1;
        cmd    = c;
        req    = 1'b1;
        waited = 0;
        while (!ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ack) begin
            $display("timeout: o_ack never rose for opcode %0d", c.op);
            errors++;
            req = 1'b0;
            return;
        end
        push_check(is_cnt, result, exp);
        for (int k = 0; k < hold; k++) begin
            @(posedge clk);
            #1;
            if (!ack) begin
                $display("FAIL o_ack: got 0x%0h, expected 0x1 with i_req held", ack);
                errors++;
            end
            push_check(is_cnt, result, exp);
        end
        req       = 1'b0;
        model_acc = exp;
        waited    = 0;
        while (ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (ack) begin
            $display("timeout: o_ack did not fall after i_req dropped");
            errors++;
        end
    endtask

    task automatic drain_checks();
        int waited;
        waited = 0;
        while (check_q.size() > 0 && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (check_q.size() > 0) begin
            $display("compare process left %0d results unchecked", check_q.size());
            errors++;
        end
    endtask

    task automatic begin_test();
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic end_test(input string name);
        drain_checks();
        $display("test %-12s checks %0d, errors %0d", name,
                 checks - test_checks0, errors - test_errors0);
    endtask

    initial begin
        op_e op;
        fx_t b;
        int  len;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        cmd       = '0;
        model_acc = '0;
        checks    = 0;
        passed    = 0;
        errors    = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test();
        if (ack !== 1'b0) begin
            $display("FAIL o_ack: got 0x%0h, expected 0x0", ack);
            errors++;
        end
        push_check(1'b0, result, '0);
        run_request(make_cmd(OP_FXMAC, '0, '0), 0);  // last result starts at zero
        end_test("reset");

        begin_test();
        for (int i = 0; i < 200; i++) begin
            op = ($urandom % 2) ? OP_FXSUB : OP_FXADD;
            run_request(make_cmd(op, rand_fx(), rand_fx()), 0);
        end
        run_request(make_cmd(OP_FXADD, 16'sh7000, 16'sh7000), 0);
        run_request(make_cmd(OP_FXADD, 16'sh9000, 16'sh9000), 0);
        run_request(make_cmd(OP_FXSUB, 16'sh7000, 16'sh9000), 0);
        run_request(make_cmd(OP_FXSUB, 16'sh8000, 16'sh0001), 0);
        run_request(make_cmd(OP_FXSUB, 16'sh0000, 16'sh8000), 0);
        end_test("add_sub");

        begin_test();
        run_request(make_cmd(OP_FXMUL, 16'sh0600, 16'sh5555), 0);  // rounds up past 0x7FFF
        run_request(make_cmd(OP_FXMAC, 16'sh0000, 16'sh0000), 0);
        run_request(make_cmd(OP_FXMUL, 16'sh7FFF, 16'sh7FFF), 0);
        run_request(make_cmd(OP_FXMUL, 16'sh8000, 16'sh7FFF), 0);
        run_request(make_cmd(OP_FXMAC, 16'sh8000, 16'sh8000), 0);
        run_request(make_cmd(OP_FXMAC, 16'sh0400, 16'shF000), 0);
        for (int c = 0; c < 25; c++) begin
            run_request(make_cmd(OP_FXMUL, rand_small(), rand_small()), 0);
            len = 1 + int'($urandom % 5);
            for (int k = 0; k < len; k++) begin
                run_request(make_cmd(OP_FXMAC, rand_small(), rand_small()), 0);
            end
        end
        end_test("mul_mac");

        begin_test();
        for (int i = 0; i < 150; i++) begin
            case ($urandom % 3)
                0: run_request(make_cmd(OP_CLZ,
                       rand_fx() & fx_t'(16'hFFFF >> ($urandom % 17)), '0), 0);
                1: run_request(make_cmd(OP_LRCW, rand_fx(), rand_fx()), 0);
                default: run_request(make_cmd(OP_LFSR, rand_fx(),
                             fx_t'($urandom % 16)), 0);
            endcase
        end
        for (int s = 0; s < 16; s++) begin
            run_request(make_cmd(OP_LFSR, 16'sh0000, fx_t'(s)), 0);
            run_request(make_cmd(OP_LFSR, 16'shFFFF, fx_t'(s)), 0);
        end
        run_request(make_cmd(OP_CLZ, 16'sh0000, '0), 0);
        run_request(make_cmd(OP_CLZ, 16'shFFFF, '0), 0);
        run_request(make_cmd(OP_LRCW, 16'sh0000, 16'shFFFF), 0);
        run_request(make_cmd(OP_LRCW, 16'shFFFF, 16'sh0000), 0);
        run_request(make_cmd(OP_LRCW, 16'shFFFF, 16'shFFFF), 0);
        run_request(make_cmd(OP_LRCW, 16'sh0000, 16'sh0000), 0);
        end_test("bit_ops");

        begin_test();
        for (int i = 0; i < 40; i++) begin
            op = pick_op($urandom);
            b  = (op == OP_LFSR) ? fx_t'($urandom % 16) : rand_small();
            run_request(make_cmd(op, rand_small(), b), int'($urandom % 11));
        end
        end_test("backpressure");

        begin_test();
        for (int i = 0; i < 3; i++) begin
            run_request(make_cmd(OP_FXADD, 16'sh1000, 16'sh0C00), 0);
            run_request(make_cmd(op_e'(UNDEF_CODES[i]), rand_fx(), rand_fx()), 0);
            run_request(make_cmd(OP_FXMAC, 16'sh0800, 16'sh0C00), 0);  // from zero
        end
        end_test("undefined_op");

        drain_checks();
        $display("closing: %0d checks passed, %0d errors", passed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+dv
design/alu_pkg.sv
design/fx_arith.sv
design/bit_ops.sv
design/alu_ctrl.sv
design/alu_top.sv
dv/alu_sva.sv
dv/alu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module alu_tb -o alu_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/alu_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $SIM_LOG"
exit 1
